/* source/link_pkg.sv */
// Fixed Hamming(12,8) packet sizes; one data wire, no clock recovery, one packet per start pulse.
package link_pkg;

	// ##########################################################
	// Packet sizes.
	// ##########################################################

	localparam int DATA_BITS     = 8;	// Payload byte.
	localparam int ENC_DATA_BITS = 12;	// Hamming(12,8) codeword.
	localparam int SYNC_BITS     = 8;	// Frame preamble.

	// Syncword goes first, codeword after it.
	localparam int FRAME_BITS = SYNC_BITS + ENC_DATA_BITS;

	// Wide enough to count a whole frame.
	localparam int CNT_BITS = 5;

	// ##########################################################
	// Syncword.
	// ##########################################################

	// Leading 1, so idle zeros never alias.
	localparam logic [SYNC_BITS-1:0] SYNCWORD = 8'hB5;

	// ##########################################################
	// Sender FSM.
	// ##########################################################

	typedef enum logic [1:0] {
		TX_IDLE = 2'd0,	// Wait for send_start.
		TX_SEND = 2'd1,	// Frame on the wire.
		TX_DONE = 2'd2	// Frame sent, done held.
	} tx_state_t;

endpackage : link_pkg

/* source/shift_reg.sv */
// Left shifter with parallel load; load wins over shift, and reset clears the whole register.
module shift_reg #(
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             rst_l,
	input  logic             en,
	input  logic             load,
	input  logic             shift_in,
	input  logic [WIDTH-1:0] d,
	output logic [WIDTH-1:0] q
);

	// Load, then shift, else hold.
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			q <= '0;
		end
		else if (load) begin
			q <= d;	// Parallel load.
		end
		else if (en) begin
			// MSB drops out, new bit enters at the LSB.
			q <= {q[WIDTH-2:0], shift_in};
		end
	end

endmodule : shift_reg

/* source/hamming_encoder.sv */
// Combinational Hamming(12,8) encoder; code index i holds position i+1, parity at 1, 2, 4, 8.
module hamming_encoder (
	input  logic [link_pkg::DATA_BITS-1:0]     data,
	output logic [link_pkg::ENC_DATA_BITS-1:0] code
);

	logic p1;	// Covers positions 3, 5, 7, 9, 11.
	logic p2;	// Covers positions 3, 6, 7, 10, 11.
	logic p4;	// Covers positions 5, 6, 7, 12.
	logic p8;	// Covers positions 9, 10, 11, 12.

	// ##########################################################
	// Parity.
	// Data bits sit at 3, 5, 6, 7, 9, 10, 11, 12,
	// so data[0] is position 3 and data[7] is position 12.
	// ##########################################################

	assign p1 = data[0] ^ data[1] ^ data[3] ^ data[4] ^ data[6];
	assign p2 = data[0] ^ data[2] ^ data[3] ^ data[5] ^ data[6];
	assign p4 = data[1] ^ data[2] ^ data[3] ^ data[7];
	assign p8 = data[4] ^ data[5] ^ data[6] ^ data[7];

	// Codeword assembly, position 12 down to 1.
	assign code = {
		data[7],	// Position 12.
		data[6],	// Position 11.
		data[5],	// Position 10.
		data[4],	// Position 9.
		p8,		// Position 8.
		data[3],	// Position 7.
		data[2],	// Position 6.
		data[1],	// Position 5.
		p4,		// Position 4.
		data[0],	// Position 3.
		p2,		// Position 2.
		p1		// Position 1.
	};

endmodule : hamming_encoder

/* source/hamming_decoder.sv */
// Combinational Hamming(12,8) decoder; fixes one flipped bit, double errors are not detected.
module hamming_decoder (
	input  logic [link_pkg::ENC_DATA_BITS-1:0] code,
	output logic [link_pkg::DATA_BITS-1:0]     data,
	output logic                               corrected
);

	localparam int SYN_BITS = 4;	// Enough to name 12 positions.

	logic [SYN_BITS-1:0]                syndrome;
	logic [link_pkg::ENC_DATA_BITS-1:0] fixed;

	// ##########################################################
	// Syndrome.
	// Bit b is the parity over every position with bit b set,
	// parity bit included, so a clean word gives zero.
	// ##########################################################

	always_comb begin
		syndrome = '0;
		for (int i = 0; i < link_pkg::ENC_DATA_BITS; i++) begin
			for (int b = 0; b < SYN_BITS; b++) begin
				if ((((i + 1) >> b) & 1) != 0) begin
					syndrome[b] = syndrome[b] ^ code[i];	// Position i+1.
				end
			end
		end
	end

	// ##########################################################
	// Correction.
	// ##########################################################

	// Syndrome names the bad position; 13 to 15 match nothing.
	always_comb begin
		for (int i = 0; i < link_pkg::ENC_DATA_BITS; i++) begin
			fixed[i] = code[i] ^ (int'(syndrome) == i + 1);
		end
	end

	// Any nonzero syndrome counts as a fix.
	assign corrected = |syndrome;

	// Data positions 12, 11, 10, 9, 7, 6, 5, 3.
	assign data = {
		fixed[11],
		fixed[10],
		fixed[9],
		fixed[8],
		fixed[6],
		fixed[5],
		fixed[4],
		fixed[2]
	};

endmodule : hamming_decoder

/* source/data_sender.sv */
// Serial frame sender; enc_word is sampled at send_start only, and a new start restarts the frame.
module data_sender (
	input  logic                               clk,
	input  logic                               rst_l,
	input  logic                               send_start,
	input  logic [link_pkg::ENC_DATA_BITS-1:0] enc_word,
	output logic                               serial_out,
	output logic                               send_done
);

	link_pkg::tx_state_t              state;
	logic [link_pkg::CNT_BITS-1:0]    send_count;	// Bits already on the wire.
	logic [link_pkg::FRAME_BITS-1:0]  frame_q;

	// ##########################################################
	// FSM and bit counter.
	// ##########################################################

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			state      <= link_pkg::TX_IDLE;
			send_count <= '0;
		end
		else if (send_start) begin
			state      <= link_pkg::TX_SEND;	// Restarts from any state.
			send_count <= '0;
		end
		else if (state == link_pkg::TX_SEND) begin
			send_count <= send_count + 1'b1;
			// Last bit is out during this cycle.
			if (int'(send_count) == link_pkg::FRAME_BITS - 1) begin
				state <= link_pkg::TX_DONE;
			end
		end
	end

	// Syncword on top, so it leaves first.
	shift_reg #(.WIDTH(link_pkg::FRAME_BITS)) frame_reg (
		.clk      (clk),
		.rst_l    (rst_l),
		.en       (state == link_pkg::TX_SEND),
		.load     (send_start),
		.shift_in (1'b0),
		.d        ({link_pkg::SYNCWORD, enc_word}),
		.q        (frame_q)
	);

	// MSB first; wire idles low.
	assign serial_out = frame_q[link_pkg::FRAME_BITS-1] & (state == link_pkg::TX_SEND);
	assign send_done  = (state == link_pkg::TX_DONE);	// Held until next start.

endmodule : data_sender

/* source/data_receiver.sv */
// Serial frame receiver; receive_start must come before the frame, one packet per start pulse.
module data_receiver (
	input  logic                               clk,
	input  logic                               rst_l,
	input  logic                               receive_start,
	input  logic                               serial_in,
	output logic [link_pkg::ENC_DATA_BITS-1:0] data_out,
	output logic                               receive_done
);

	logic                            listen;		// Armed by receive_start.
	logic                            sync_done;
	logic                            data_en;
	logic [link_pkg::SYNC_BITS-1:0]  sync_q;
	logic [link_pkg::CNT_BITS-1:0]   receive_count;

	// Listen flag, stays set once armed.
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			listen <= 1'b0;
		end
		else if (receive_start) begin
			listen <= 1'b1;
		end
	end

	// ##########################################################
	// Syncword search.
	// ##########################################################

	// Frozen once the syncword sits in it.
	shift_reg #(.WIDTH(link_pkg::SYNC_BITS)) sync_detection (
		.clk      (clk),
		.rst_l    (rst_l),
		.en       (listen & ~sync_done),
		.load     (receive_start),	// Clears the last match.
		.shift_in (serial_in),
		.d        ('0),
		.q        (sync_q)
	);

	assign sync_done = (sync_q == link_pkg::SYNCWORD);

	// ##########################################################
	// Codeword capture.
	// ##########################################################

	assign data_en = sync_done & ~receive_done;	// Stops after 12 bits.

	shift_reg #(.WIDTH(link_pkg::ENC_DATA_BITS)) data_reg (
		.clk      (clk),
		.rst_l    (rst_l),
		.en       (data_en),
		.load     (receive_start),
		.shift_in (serial_in),
		.d        ('0),
		.q        (data_out)
	);

	// Codeword bits taken so far.
	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			receive_count <= '0;
		end
		else if (receive_start) begin
			receive_count <= '0;
		end
		else if (data_en) begin
			receive_count <= receive_count + 1'b1;
		end
	end

	assign receive_done = (int'(receive_count) == link_pkg::ENC_DATA_BITS);

endmodule : data_receiver

/* source/serial_link_top.sv */
// Link top level; serial_out and serial_in stay apart so an outside channel can corrupt bits.
module serial_link_top (
	input  logic                           clk,
	input  logic                           rst_l,
	input  logic [link_pkg::DATA_BITS-1:0] tx_data,
	input  logic                           send_start,
	input  logic                           receive_start,
	input  logic                           serial_in,
	output logic                           serial_out,
	output logic                           send_done,
	output logic [link_pkg::DATA_BITS-1:0] rx_data,
	output logic                           corrected,
	output logic                           receive_done
);

	logic [link_pkg::ENC_DATA_BITS-1:0] enc_word;	// Encoder to sender.
	logic [link_pkg::ENC_DATA_BITS-1:0] rx_word;	// Receiver to decoder.

	// ##########################################################
	// Send side.
	// ##########################################################

	hamming_encoder encoder0 (
		.data (tx_data),
		.code (enc_word)
	);

	data_sender sender0 (
		.clk        (clk),
		.rst_l      (rst_l),
		.send_start (send_start),
		.enc_word   (enc_word),
		.serial_out (serial_out),
		.send_done  (send_done)
	);

	// ##########################################################
	// Receive side.
	// ##########################################################

	data_receiver receiver0 (
		.clk           (clk),
		.rst_l         (rst_l),
		.receive_start (receive_start),
		.serial_in     (serial_in),
		.data_out      (rx_word),
		.receive_done  (receive_done)
	);

	// Outputs valid while receive_done is high.
	hamming_decoder decoder0 (
		.code      (rx_word),
		.data      (rx_data),
		.corrected (corrected)
	);

endmodule : serial_link_top

/* verif/clock_gen.sv */
// 10 ns clock from time 0; rst_l low for RESET_CYCLES rising edges, released on a falling edge.
module clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_l
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period.
	end

	initial begin
		rst_l = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_l = 1'b1;	// Clear of any rising edge.
	end

endmodule : clock_gen

/* verif/serial_link_asserts.sv */
// One checker bound into sender and receiver; each copy ties the other side's ports to idle.
module serial_link_asserts (
	input logic                clk,
	input logic                rst_l,
	input logic                send_start,
	input logic                send_done,
	input logic                serial_out,
	input link_pkg::tx_state_t state,
	input logic                receive_start,
	input logic                receive_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// ##########################################################
	// Sender.
	// ##########################################################

	// Done FRAME_BITS+1 cycles after the start edge.
	send_done_late: assert property (@(posedge clk) disable iff (!rst_l)
		send_start |-> ##(link_pkg::FRAME_BITS + 1) send_done)
		else $error("send_done missing after send_start");

	// And not before.
	send_done_early: assert property (@(posedge clk) disable iff (!rst_l)
		$rose(send_done) |-> $past(send_start, link_pkg::FRAME_BITS + 1))
		else $error("send_done rose without a matching send_start");

	idle_wire_low: assert property (@(posedge clk) disable iff (!rst_l)
		state != link_pkg::TX_SEND |-> !serial_out)	// Wire idles low.
		else $error("serial_out high outside TX_SEND");

	// ##########################################################
	// Receiver.
	// ##########################################################

	done_held: assert property (@(posedge clk) disable iff (!rst_l)
		receive_done && !receive_start |=> receive_done)
		else $error("receive_done dropped before receive_start");

endmodule : serial_link_asserts

// Sender copy.
bind data_sender serial_link_asserts sender_chk (
	.clk(clk), .rst_l(rst_l),
	.send_start(send_start), .send_done(send_done),
	.serial_out(serial_out), .state(state),
	.receive_start(1'b0), .receive_done(1'b0)
);

// Receiver copy.
bind data_receiver serial_link_asserts receiver_chk (
	.clk(clk), .rst_l(rst_l),
	.send_start(1'b0), .send_done(1'b0),
	.serial_out(1'b0), .state(link_pkg::TX_IDLE),
	.receive_start(receive_start), .receive_done(receive_done)
);

/* verif/tb_serial_link.sv */
// Loop-back testbench; the channel inverts at most one frame bit per packet, counted from bit 0.
module tb_serial_link;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DW           = link_pkg::DATA_BITS;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 12;
	localparam int NUM_SYNC     = 4;
	localparam int NUM_PACKETS  = 3 + NUM_RANDOM + 2 * NUM_SYNC;
	localparam int SYNC_WAIT    = link_pkg::FRAME_BITS + 10;	// Window for a damaged frame.

	logic          clk;
	logic          rst_l;
	logic [DW-1:0] tx_data;
	logic          send_start;
	logic          receive_start;
	logic          serial_in;
	logic          serial_out;
	logic          send_done;
	logic [DW-1:0] rx_data;
	logic          corrected;
	logic          receive_done;

	int            err_pos;		// Frame bit to invert, -1 for none.
	int            frame_pos;	// Frame bit now on the wire.
	int            value_errors;
	int            other_errors;
	int            sync_misses;
	bit            run_ended;
	logic          done_q;
	logic [DW-1:0] exp_data_q[$];
	logic          exp_flag_q[$];
	string         exp_name_q[$];

	clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clk_gen0 (.clk(clk), .rst_l(rst_l));

	serial_link_top dut0 (.*);

	// One error is always repaired; corrected only if it hit the codeword.
	function automatic logic [DW-1:0] ref_decode(input logic [DW-1:0] sent, input int pos,
			output logic flag);
		flag = (pos >= link_pkg::SYNC_BITS) && (pos < link_pkg::FRAME_BITS);
		return sent;
	endfunction

	task automatic compare_data(input string name, input logic [DW-1:0] exp,
			input logic [DW-1:0] act);
		if (act !== exp) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic compare_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	// ##########################################################
	// Channel.
	// ##########################################################

	// Bit k sits on the wire after edge k; copied at mid-cycle.
	initial begin
		serial_in <= 1'b0;
		frame_pos <= link_pkg::FRAME_BITS;	// Idle, never equals err_pos.
		forever begin
			@(posedge clk);
			frame_pos <= send_start ? 0 : frame_pos + int'(frame_pos < link_pkg::FRAME_BITS);
			@(negedge clk);
			serial_in <= serial_out ^ (frame_pos == err_pos);
		end
	end

	// One result per rising receive_done.
	initial begin
		done_q = 1'b0;
		forever begin
			@(negedge clk);
			if (receive_done && !done_q) begin
				if (exp_data_q.size() == 0) begin
					$display("receive_done rose while no packet was expected");
					other_errors++;
				end
				else begin
					compare_data({exp_name_q[0], " rx_data"}, exp_data_q.pop_front(), rx_data);
					compare_flag({exp_name_q.pop_front(), " corrected"}, exp_flag_q.pop_front(),
						corrected);
				end
			end
			done_q = receive_done;
		end
	end

	// ##########################################################
	// Stimulus.
	// ##########################################################

	// Arms the receiver, then starts one frame.
	task automatic send_packet(input logic [DW-1:0] data, input int pos, input string name);
		logic          exp_flag;
		logic [DW-1:0] exp_data;
		@(negedge clk);
		receive_start = 1'b1;
		@(negedge clk);
		receive_start = 1'b0;
		compare_flag({name, " done cleared"}, 1'b0, receive_done);
		// Syncword hit, no result.
		if (pos >= link_pkg::SYNC_BITS || pos < 0) begin
			exp_data = ref_decode(data, pos, exp_flag);
			exp_data_q.push_back(exp_data);
			exp_flag_q.push_back(exp_flag);
			exp_name_q.push_back(name);
		end
		tx_data    = data;
		err_pos    = pos;
		send_start = 1'b1;
		@(negedge clk);
		send_start = 1'b0;
	endtask

	// Sends, then times both done flags from the start edge.
	task automatic run_packet(input logic [DW-1:0] data, input int pos, input string name);
		int cycles;
		int send_cycles;
		send_packet(data, pos, name);
		cycles      = 1;
		send_cycles = 0;
		while (!receive_done) begin
			@(negedge clk);
			cycles++;
			if (send_done && send_cycles == 0) begin
				send_cycles = cycles;
			end
		end
		compare_cycles({name, " send latency"}, link_pkg::FRAME_BITS + 1, send_cycles);
		compare_cycles({name, " receive latency"}, link_pkg::FRAME_BITS + 1, cycles);
	endtask

	initial begin : stimulus
		int            pos;
		tx_data       = '0;
		send_start    = 1'b0;
		receive_start = 1'b0;
		err_pos       = -1;
		value_errors  = 0;
		other_errors  = 0;
		sync_misses   = 0;
		run_ended     = 1'b0;
		void'($urandom(32'he047_d4ea));
		@(posedge rst_l);
		@(negedge clk);
		compare_flag("reset serial_out", 1'b0, serial_out);
		compare_flag("reset send_done", 1'b0, send_done);
		compare_flag("reset receive_done", 1'b0, receive_done);
		run_packet(8'h00, -1, "clean 00");
		run_packet(8'hFF, -1, "clean FF");
		run_packet(8'hA5, -1, "clean A5");
		repeat (50) @(negedge clk);	// Idle, result must hold.
		compare_flag("hold receive_done", 1'b1, receive_done);
		compare_data("hold rx_data", 8'hA5, rx_data);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			pos = link_pkg::SYNC_BITS + int'($urandom_range(link_pkg::ENC_DATA_BITS - 1, 0));
			run_packet(DW'($urandom), pos, "codeword error");
		end
		// All-zero codeword, a damaged syncword then never matches.
		for (int i = 0; i < NUM_SYNC; i++) begin
			send_packet(8'h00, int'($urandom_range(link_pkg::SYNC_BITS - 1, 0)), "sync error");
			repeat (SYNC_WAIT) @(negedge clk);
			if (!receive_done) begin
				sync_misses++;
			end
			run_packet(DW'($urandom), -1, "retry");
		end
		compare_cycles("syncword timeouts", NUM_SYNC, sync_misses);
		@(posedge clk);	// Last result compared on the previous falling edge.
		if (exp_data_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_data_q.size());
			other_errors++;
		end
		$display("Summary: %0d value errors, %0d other errors, %0d syncword timeouts",
			value_errors, other_errors, sync_misses);
		run_ended = 1'b1;
		if (value_errors + other_errors == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Budget of FRAME_BITS+20 cycles per packet.
	initial begin
		repeat (NUM_PACKETS * (link_pkg::FRAME_BITS + 20) + RESET_CYCLES) @(posedge clk);
		$display("Watchdog expired, receive_done never came");
		run_ended = 1'b1;
		$display("TEST FAIL");
		$finish;
	end

	// Run cut short before the summary.
	final begin
		if (!run_ended) begin
			$display("TEST FAIL");
		end
	end

endmodule : tb_serial_link

/* flist.f */
source/link_pkg.sv
source/shift_reg.sv
source/hamming_encoder.sv
source/hamming_decoder.sv
source/data_sender.sv
source/data_receiver.sv
source/serial_link_top.sv
verif/clock_gen.sv
verif/serial_link_asserts.sv
verif/tb_serial_link.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_serial_link \
	-f flist.f -o sim_serial_link &&
	./obj_dir/sim_serial_link | tee /dev/stderr | grep -q "^TEST PASS$" &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
